/* c906_irq.f */
hdl/c906_irq_pkg.sv
hdl/apb_decode.sv
hdl/clint.sv
hdl/plic.sv
hdl/sysio.sv
hdl/c906_irq_top.sv
tests/tb_clkgen.sv
tests/tb_c906_irq.sv

/* hdl/apb_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module apb_decode
  import c906_irq_pkg::*;
(
  input  logic                  pll_core_cpuclk,
  input  logic                  reset,
  input  logic [APB_ADDR_W-1:0] paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic [APB_DATA_W-1:0] clint_prdata,
  input  logic                  clint_pslverr,
  input  logic [APB_DATA_W-1:0] plic_prdata,
  input  logic                  plic_pslverr,
  output logic                  clint_psel,
  output logic                  plic_psel,
  output logic [APB_DATA_W-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr
);

  apb_target_e tgt;

  // region select on the upper address bits
  always_comb begin
    if (paddr[APB_ADDR_W-1:OFS_W] == CLINT_BASE[APB_ADDR_W-1:OFS_W])
      tgt = TGT_CLINT;
    else if (paddr[APB_ADDR_W-1:OFS_W] == PLIC_BASE[APB_ADDR_W-1:OFS_W])
      tgt = TGT_PLIC;
    else
      tgt = TGT_NONE;
  end

  assign clint_psel = psel && (tgt == TGT_CLINT);
  assign plic_psel  = psel && (tgt == TGT_PLIC);
  assign pready     = psel && penable; // zero wait

  //==========================================================
  //  read data and error merge
  //==========================================================
  always_comb begin
    case (tgt)
      TGT_CLINT: begin
        prdata  = clint_prdata;
        pslverr = clint_pslverr;
      end
      TGT_PLIC: begin
        prdata  = plic_prdata;
        pslverr = plic_pslverr;
      end
      default: begin
        prdata  = '0;
        pslverr = psel && penable; // unmapped
      end
    endcase
  end

  a_one_slave: assert property (@(posedge pll_core_cpuclk) disable iff (reset)
    !(clint_psel && plic_psel));

  a_ready_sel: assert property (@(posedge pll_core_cpuclk) disable iff (reset)
    pready |-> psel);

endmodule

`default_nettype wire

/* hdl/c906_irq_pkg.sv */
`default_nettype none

package c906_irq_pkg;

  //==========================================================
  //  bus and counter widths
  //==========================================================
  localparam int APB_ADDR_W    = 32;
  localparam int APB_DATA_W    = 32;
  localparam int MTIME_W       = 64;

  localparam int PLIC_INT_NUM  = 16; // source 0 reserved
  localparam int PLIC_ID_W     = 4;
  localparam int PLIC_PRIO_BIT = 3;

  //==========================================================
  //  address map
  //==========================================================
  // 64 MB regions, picked by paddr[31:26]
  localparam int OFS_W = 26;

  localparam logic [APB_ADDR_W-1:0] CLINT_BASE = 32'h0400_0000;
  localparam logic [APB_ADDR_W-1:0] PLIC_BASE  = 32'h0000_0000;

  localparam logic [OFS_W-1:0] CLINT_MSIP_OFS        = 26'h000_0000;
  localparam logic [OFS_W-1:0] CLINT_MTIMECMP_LO_OFS = 26'h000_4000;
  localparam logic [OFS_W-1:0] CLINT_MTIMECMP_HI_OFS = 26'h000_4004;
  localparam logic [OFS_W-1:0] CLINT_MTIME_LO_OFS    = 26'h000_bff8;
  localparam logic [OFS_W-1:0] CLINT_MTIME_HI_OFS    = 26'h000_bffc;

  localparam logic [OFS_W-1:0] PLIC_PRIO_OFS    = 26'h000_0000; // source n at 4*n
  localparam logic [OFS_W-1:0] PLIC_PENDING_OFS = 26'h000_1000;
  localparam logic [OFS_W-1:0] PLIC_ENABLE_OFS  = 26'h000_2000;
  localparam logic [OFS_W-1:0] PLIC_THRESH_OFS  = 26'h020_0000;
  localparam logic [OFS_W-1:0] PLIC_CLAIM_OFS   = 26'h020_0004;

  //==========================================================
  //  decode enums
  //==========================================================
  typedef enum logic [1:0] {
    TGT_NONE,
    TGT_CLINT,
    TGT_PLIC
  } apb_target_e;

  typedef enum logic [2:0] {
    MSIP,
    MTIMECMP_LO,
    MTIMECMP_HI,
    MTIME_LO,
    MTIME_HI,
    CLINT_BAD
  } clint_reg_e;

  // labels share the package scope with clint_reg_e
  typedef enum logic [2:0] {
    PRIO,
    PENDING,
    ENABLE,
    THRESH,
    CLAIM,
    PLIC_BAD
  } plic_reg_e;

endpackage

`default_nettype wire

/* hdl/c906_irq_top.sv */
`timescale 1ns/1ns
`default_nettype none

module c906_irq_top
  import c906_irq_pkg::*;
(
  input  logic                    pll_core_cpuclk,
  input  logic                    reset,
  input  logic [APB_ADDR_W-1:0]   paddr,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [APB_DATA_W-1:0]   pwdata,
  input  logic [MTIME_W-1:0]      pad_cpu_sys_cnt,
  input  logic [PLIC_INT_NUM-1:0] pad_plic_int_vld,
  input  logic [PLIC_INT_NUM-1:0] pad_plic_int_cfg,
  input  logic [1:0]              core0_lpmd_b,
  output logic [APB_DATA_W-1:0]   prdata,
  output logic                    pready,
  output logic                    pslverr,
  output logic                    core0_ms_int,
  output logic                    core0_mt_int,
  output logic                    core0_me_int,
  output logic                    core0_wake
);

  logic                  clint_psel;
  logic                  plic_psel;
  logic [APB_DATA_W-1:0] clint_prdata;
  logic                  clint_pslverr;
  logic [APB_DATA_W-1:0] plic_prdata;
  logic                  plic_pslverr;
  logic [MTIME_W-1:0]    mtime;
  logic                  ms_req;
  logic                  mt_req;
  logic                  me_req;

  //==========================================================
  //  bus fan-out
  //==========================================================
  apb_decode x_apb_decode (
    .pll_core_cpuclk (pll_core_cpuclk),
    .reset           (reset          ),
    .paddr           (paddr          ),
    .psel            (psel           ),
    .penable         (penable        ),
    .clint_prdata    (clint_prdata   ),
    .clint_pslverr   (clint_pslverr  ),
    .plic_prdata     (plic_prdata    ),
    .plic_pslverr    (plic_pslverr   ),
    .clint_psel      (clint_psel     ),
    .plic_psel       (plic_psel      ),
    .prdata          (prdata         ),
    .pready          (pready         ),
    .pslverr         (pslverr        )
  );

  //==========================================================
  //  interrupt controllers
  //==========================================================
  clint x_clint (
    .pll_core_cpuclk (pll_core_cpuclk),
    .reset           (reset          ),
    .psel            (clint_psel     ),
    .penable         (penable        ),
    .pwrite          (pwrite         ),
    .paddr           (paddr          ),
    .pwdata          (pwdata         ),
    .mtime           (mtime          ),
    .prdata          (clint_prdata   ),
    .pslverr         (clint_pslverr  ),
    .ms_req          (ms_req         ),
    .mt_req          (mt_req         )
  );

  plic x_plic (
    .pll_core_cpuclk (pll_core_cpuclk ),
    .reset           (reset           ),
    .psel            (plic_psel       ),
    .penable         (penable         ),
    .pwrite          (pwrite          ),
    .paddr           (paddr           ),
    .pwdata          (pwdata          ),
    .int_vld         (pad_plic_int_vld),
    .int_cfg         (pad_plic_int_cfg),
    .prdata          (plic_prdata     ),
    .pslverr         (plic_pslverr    ),
    .me_req          (me_req          )
  );

  sysio x_sysio (
    .pll_core_cpuclk (pll_core_cpuclk),
    .reset           (reset          ),
    .pad_cpu_sys_cnt (pad_cpu_sys_cnt),
    .ms_req          (ms_req         ),
    .mt_req          (mt_req         ),
    .me_req          (me_req         ),
    .core0_lpmd_b    (core0_lpmd_b   ),
    .mtime           (mtime          ),
    .core0_ms_int    (core0_ms_int   ),
    .core0_mt_int    (core0_mt_int   ),
    .core0_me_int    (core0_me_int   ),
    .core0_wake      (core0_wake     )
  );

endmodule

`default_nettype wire

/* hdl/clint.sv */
`timescale 1ns/1ns
`default_nettype none

module clint
  import c906_irq_pkg::*;
(
  input  logic                  pll_core_cpuclk,
  input  logic                  reset,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [APB_ADDR_W-1:0] paddr,
  input  logic [APB_DATA_W-1:0] pwdata,
  input  logic [MTIME_W-1:0]    mtime,
  output logic [APB_DATA_W-1:0] prdata,
  output logic                  pslverr,
  output logic                  ms_req,
  output logic                  mt_req
);

  clint_reg_e             reg_sel;
  logic                   acc;
  logic                   bad;
  logic                   msip;
  logic [MTIME_W-1:0]     mtimecmp;
  logic [APB_DATA_W-1:0]  rdata;

  always_comb begin
    case (paddr[OFS_W-1:0])
      CLINT_MSIP_OFS:        reg_sel = MSIP;
      CLINT_MTIMECMP_LO_OFS: reg_sel = MTIMECMP_LO;
      CLINT_MTIMECMP_HI_OFS: reg_sel = MTIMECMP_HI;
      CLINT_MTIME_LO_OFS:    reg_sel = MTIME_LO;
      CLINT_MTIME_HI_OFS:    reg_sel = MTIME_HI;
      default:               reg_sel = CLINT_BAD;
    endcase
  end

  assign acc = psel && penable;
  // mtime is read only
  assign bad = (reg_sel == CLINT_BAD) ||
               (pwrite && (reg_sel == MTIME_LO || reg_sel == MTIME_HI));

  always_comb begin
    case (reg_sel)
      MSIP:        rdata = {{(APB_DATA_W-1){1'b0}}, msip};
      MTIMECMP_LO: rdata = mtimecmp[APB_DATA_W-1:0];
      MTIMECMP_HI: rdata = mtimecmp[MTIME_W-1:APB_DATA_W];
      MTIME_LO:    rdata = mtime[APB_DATA_W-1:0];
      MTIME_HI:    rdata = mtime[MTIME_W-1:APB_DATA_W];
      default:     rdata = '0;
    endcase
  end

  assign prdata  = bad ? '0 : rdata;
  assign pslverr = acc && bad;

  //==========================================================
  //  registers and request flops
  //==========================================================
  always_ff @(posedge pll_core_cpuclk) begin
    if (reset) begin
      msip     <= 1'b0;
      mtimecmp <= '1; // no timer irq until programmed
      ms_req   <= 1'b0;
      mt_req   <= 1'b0;
    end else begin
      if (acc && pwrite && !bad) begin
        case (reg_sel)
          MSIP:        msip <= pwdata[0];
          MTIMECMP_LO: mtimecmp[APB_DATA_W-1:0] <= pwdata;
          MTIMECMP_HI: mtimecmp[MTIME_W-1:APB_DATA_W] <= pwdata;
          default:     ;
        endcase
      end
      ms_req <= msip;
      mt_req <= (mtime >= mtimecmp);
    end
  end

endmodule

`default_nettype wire

/* hdl/plic.sv */
`timescale 1ns/1ns
`default_nettype none

module plic
  import c906_irq_pkg::*;
(
  input  logic                    pll_core_cpuclk,
  input  logic                    reset,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [APB_ADDR_W-1:0]   paddr,
  input  logic [APB_DATA_W-1:0]   pwdata,
  input  logic [PLIC_INT_NUM-1:0] int_vld,
  input  logic [PLIC_INT_NUM-1:0] int_cfg,  // 1 pulse, 0 level
  output logic [APB_DATA_W-1:0]   prdata,
  output logic                    pslverr,
  output logic                    me_req
);

  plic_reg_e                 reg_sel;
  logic [OFS_W-1:0]          ofs;
  logic [PLIC_ID_W-1:0]      prio_idx;
  logic                      acc;
  logic                      bad;
  logic                      claim_rd;

  logic [PLIC_PRIO_BIT-1:0]  prio [PLIC_INT_NUM];
  logic [PLIC_INT_NUM-1:0]   pending;
  logic [PLIC_INT_NUM-1:0]   enable;
  logic [PLIC_PRIO_BIT-1:0]  thresh;
  logic [PLIC_INT_NUM-1:0]   int_vld_q;
  logic [PLIC_INT_NUM-1:0]   set_vec;
  logic [PLIC_INT_NUM-1:0]   clr_vec;

  logic [PLIC_ID_W-1:0]      win_id;
  logic [PLIC_PRIO_BIT-1:0]  win_prio;
  logic [APB_DATA_W-1:0]     rdata;

  //==========================================================
  //  register decode
  //==========================================================
  assign ofs      = paddr[OFS_W-1:0];
  assign prio_idx = ofs[PLIC_ID_W+1:2];

  always_comb begin
    if (ofs[OFS_W-1:PLIC_ID_W+2] == PLIC_PRIO_OFS[OFS_W-1:PLIC_ID_W+2])
      reg_sel = PRIO;
    else if (ofs == PLIC_PENDING_OFS)
      reg_sel = PENDING;
    else if (ofs == PLIC_ENABLE_OFS)
      reg_sel = ENABLE;
    else if (ofs == PLIC_THRESH_OFS)
      reg_sel = THRESH;
    else if (ofs == PLIC_CLAIM_OFS)
      reg_sel = CLAIM;
    else
      reg_sel = PLIC_BAD;
  end

  assign acc      = psel && penable;
  assign bad      = (reg_sel == PLIC_BAD) || (pwrite && reg_sel == PENDING);
  assign claim_rd = acc && !pwrite && (reg_sel == CLAIM);

  //==========================================================
  //  gateway and arbiter
  //==========================================================
  assign set_vec = (int_cfg & int_vld & ~int_vld_q) | (~int_cfg & int_vld);

  // highest priority wins, ascending scan keeps the lowest id on a tie
  always_comb begin
    win_id   = '0;
    win_prio = '0;
    for (int i = 1; i < PLIC_INT_NUM; i++) begin
      if (pending[i] && enable[i] && prio[i] > win_prio) begin
        win_id   = PLIC_ID_W'(i);
        win_prio = prio[i];
      end
    end
  end

  always_comb begin
    clr_vec = '0;
    if (claim_rd)
      clr_vec[win_id] = 1'b1;
  end

  always_comb begin
    case (reg_sel)
      PRIO:    rdata = APB_DATA_W'(prio[prio_idx]);
      PENDING: rdata = APB_DATA_W'(pending);
      ENABLE:  rdata = APB_DATA_W'(enable);
      THRESH:  rdata = APB_DATA_W'(thresh);
      CLAIM:   rdata = APB_DATA_W'(win_id);
      default: rdata = '0;
    endcase
  end

  assign prdata  = bad ? '0 : rdata;
  assign pslverr = acc && bad;

  always_ff @(posedge pll_core_cpuclk) begin
    if (reset) begin
      for (int i = 0; i < PLIC_INT_NUM; i++)
        prio[i] <= '0;
      pending   <= '0;
      enable    <= '0;
      thresh    <= '0;
      int_vld_q <= '0;
      me_req    <= 1'b0;
    end else begin
      int_vld_q <= int_vld;
      // set beats clear, so a held level source pends again
      pending   <= ((pending & ~clr_vec) | set_vec) & ~PLIC_INT_NUM'(1);
      if (acc && pwrite && !bad) begin
        case (reg_sel)
          PRIO: begin
            if (prio_idx != '0)
              prio[prio_idx] <= pwdata[PLIC_PRIO_BIT-1:0];
          end
          ENABLE:  enable <= pwdata[PLIC_INT_NUM-1:0];
          THRESH:  thresh <= pwdata[PLIC_PRIO_BIT-1:0];
          default: ; // claim write is a completion
        endcase
      end
      me_req <= (win_id != '0) && (win_prio > thresh);
    end
  end

  a_me_winner: assert property (@(posedge pll_core_cpuclk) disable iff (reset)
    me_req |-> $past(win_id != '0));

endmodule

`default_nettype wire

/* hdl/sysio.sv */
`timescale 1ns/1ns
`default_nettype none

module sysio
  import c906_irq_pkg::*;
(
  input  logic               pll_core_cpuclk,
  input  logic               reset,
  input  logic [MTIME_W-1:0] pad_cpu_sys_cnt,
  input  logic               ms_req,
  input  logic               mt_req,
  input  logic               me_req,
  input  logic [1:0]         core0_lpmd_b,   // 00 is wfi
  output logic [MTIME_W-1:0] mtime,
  output logic               core0_ms_int,
  output logic               core0_mt_int,
  output logic               core0_me_int,
  output logic               core0_wake
);

  logic any_req;

  assign any_req = ms_req || mt_req || me_req;

  //==========================================================
  //  counter sample and core interrupt flops
  //==========================================================
  always_ff @(posedge pll_core_cpuclk) begin
    if (reset) begin
      mtime        <= '0;
      core0_ms_int <= 1'b0;
      core0_mt_int <= 1'b0;
      core0_me_int <= 1'b0;
      core0_wake   <= 1'b0;
    end else begin
      mtime        <= pad_cpu_sys_cnt;
      core0_ms_int <= ms_req;
      core0_mt_int <= mt_req;
      core0_me_int <= me_req;
      core0_wake   <= any_req && (core0_lpmd_b == 2'b00);
    end
  end

  // wake only ever comes out of low-power wait
  a_wake_lpmd: assert property (@(posedge pll_core_cpuclk) disable iff (reset)
    $rose(core0_wake) |-> ($past(core0_lpmd_b) == 2'b00));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_c906_irq \
  -f c906_irq.f -o sim_c906_irq

./obj_dir/sim_c906_irq | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
  echo "run_sim: pass"
else
  echo "run_sim: fail"
  exit 1
fi

/* tests/tb_c906_irq.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_c906_irq
  import c906_irq_pkg::*;
();

  localparam int N_SOFT  = 16;
  localparam int N_TIMER = 24;
  localparam int N_PLIC  = 40;
  localparam int N_ERR   = 16;
  localparam int N_WAKE  = 16;
  // rough cycles per test, twice over for margin
  localparam int CYCLE_LIMIT = 2 * (8 + 20 + N_SOFT * 10 + N_TIMER * 28 + N_PLIC * 44
                                    + N_ERR * 3 + 24 + N_WAKE * 12);

  logic                    clk;
  logic                    reset;
  logic [APB_ADDR_W-1:0]   paddr;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [APB_DATA_W-1:0]   pwdata;
  logic [MTIME_W-1:0]      pad_cpu_sys_cnt;
  logic [PLIC_INT_NUM-1:0] pad_plic_int_vld;
  logic [PLIC_INT_NUM-1:0] pad_plic_int_cfg;
  logic [1:0]              core0_lpmd_b;
  logic [APB_DATA_W-1:0]   prdata;
  logic                    pready;
  logic                    pslverr;
  logic                    core0_ms_int;
  logic                    core0_mt_int;
  logic                    core0_me_int;
  logic                    core0_wake;

  // reference model state
  logic                     m_msip;
  logic [MTIME_W-1:0]       m_cmp;
  logic [MTIME_W-1:0]       m_cnt;
  logic [PLIC_PRIO_BIT-1:0] m_prio [PLIC_INT_NUM];
  logic [PLIC_INT_NUM-1:0]  m_enable;
  logic [PLIC_PRIO_BIT-1:0] m_thresh;
  logic [PLIC_INT_NUM-1:0]  m_pend;
  logic [PLIC_INT_NUM-1:0]  m_vld_q;

  logic [31:0] lfsr;
  int          cycles;
  int          n_checks;
  int          n_data_err;
  int          n_resp_err;
  int          n_irq_err;

  tb_clkgen clkgen_i (.clk(clk));

  c906_irq_top c906_irq_top_i (
    .pll_core_cpuclk  (clk             ),
    .reset            (reset           ),
    .paddr            (paddr           ),
    .psel             (psel            ),
    .penable          (penable         ),
    .pwrite           (pwrite          ),
    .pwdata           (pwdata          ),
    .pad_cpu_sys_cnt  (pad_cpu_sys_cnt ),
    .pad_plic_int_vld (pad_plic_int_vld),
    .pad_plic_int_cfg (pad_plic_int_cfg),
    .core0_lpmd_b     (core0_lpmd_b    ),
    .prdata           (prdata          ),
    .pready           (pready          ),
    .pslverr          (pslverr         ),
    .core0_ms_int     (core0_ms_int    ),
    .core0_mt_int     (core0_mt_int    ),
    .core0_me_int     (core0_me_int    ),
    .core0_wake       (core0_wake      )
  );

  //============================================================
  //  random numbers and model rules
  //============================================================
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  // top priority first, lowest id first within a level
  function automatic logic [PLIC_ID_W-1:0] winner_id();
    logic [PLIC_ID_W-1:0] id;
    int                   p;
    int                   s;
    id = '0;
    for (p = (1 << PLIC_PRIO_BIT) - 1; p > 0 && id == '0; p--)
      for (s = 1; s < PLIC_INT_NUM && id == '0; s++)
        if (m_pend[s] && m_enable[s] && int'(m_prio[s]) == p)
          id = PLIC_ID_W'(s);
    return id;
  endfunction

  function automatic logic me_expected();
    logic [PLIC_ID_W-1:0] w;
    w = winner_id();
    return (w != '0) && (m_prio[w] > m_thresh);
  endfunction

  // pending bits follow the source lines and claim reads cycle by cycle
  always @(posedge clk) begin
    logic [PLIC_INT_NUM-1:0] set_v;
    logic [PLIC_INT_NUM-1:0] clr_v;
    clr_v = '0;
    if (psel && penable && !pwrite && paddr == (PLIC_BASE | APB_ADDR_W'(PLIC_CLAIM_OFS)))
      clr_v[winner_id()] = 1'b1;
    set_v = (pad_plic_int_cfg & pad_plic_int_vld & ~m_vld_q) |
            (~pad_plic_int_cfg & pad_plic_int_vld);
    if (reset) begin
      m_pend  <= '0;
      m_vld_q <= '0;
    end else begin
      m_pend  <= ((m_pend & ~clr_v) | set_v) & ~PLIC_INT_NUM'(1);
      m_vld_q <= pad_plic_int_vld;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  //============================================================
  //  compare tasks and bus access
  //============================================================
  task automatic data_check(input string name, input logic [APB_DATA_W-1:0] exp,
                            input logic [APB_DATA_W-1:0] act);
    n_checks++;
    if (act !== exp) begin
      n_data_err++;
      $display("ERR %s exp=%h act=%h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic resp_check(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      n_resp_err++;
      $display("ERR %s exp=%h act=%h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic irq_check(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      n_irq_err++;
      $display("ERR %s exp=%h act=%h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic settle(input int n);
    repeat (n) @(posedge clk);
    @(negedge clk);
  endtask

  // setup cycle, access cycle, returns at the completing edge
  task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                          input logic [APB_DATA_W-1:0] wdata,
                          output logic [APB_DATA_W-1:0] rdata, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    resp_check("pready", 1'b1, pready);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic bus_write(input logic [APB_ADDR_W-1:0] addr,
                           input logic [APB_DATA_W-1:0] data);
    logic [APB_DATA_W-1:0] rd;
    logic                  err;
    apb_xfer(1'b1, addr, data, rd, err);
    resp_check("pslverr", 1'b0, err);
  endtask

  task automatic bus_read_check(input logic [APB_ADDR_W-1:0] addr,
                                input logic [APB_DATA_W-1:0] exp);
    logic [APB_DATA_W-1:0] rd;
    logic                  err;
    apb_xfer(1'b0, addr, '0, rd, err);
    resp_check("pslverr", 1'b0, err);
    data_check("prdata", exp, rd);
  endtask

  //============================================================
  //  tests
  //============================================================
  task automatic after_reset_checks();
    @(negedge clk);
    irq_check("core0_ms_int", 1'b0, core0_ms_int);
    irq_check("core0_mt_int", 1'b0, core0_mt_int);
    irq_check("core0_me_int", 1'b0, core0_me_int);
    irq_check("core0_wake", 1'b0, core0_wake);
    resp_check("pslverr", 1'b0, pslverr);
    bus_read_check(CLINT_BASE | APB_ADDR_W'(CLINT_MTIMECMP_LO_OFS), 32'hffff_ffff);
    bus_read_check(CLINT_BASE | APB_ADDR_W'(CLINT_MTIMECMP_HI_OFS), 32'hffff_ffff);
    bus_read_check(PLIC_BASE | APB_ADDR_W'(PLIC_CLAIM_OFS), '0);
  endtask

  task automatic soft_irq_test();
    logic [APB_DATA_W-1:0] wd;
    logic                  prev;
    int                    n;
    for (n = 0; n < N_SOFT; n++) begin
      wd   = APB_DATA_W'(rand_bits(APB_DATA_W));
      prev = m_msip;
      bus_write(CLINT_BASE | APB_ADDR_W'(CLINT_MSIP_OFS), wd);
      m_msip = wd[0];
      // one edge after the write the core line still holds the old bit
      settle(1);
      irq_check("core0_ms_int", prev, core0_ms_int);
      settle(1);
      irq_check("core0_ms_int", m_msip, core0_ms_int);
      bus_read_check(CLINT_BASE | APB_ADDR_W'(CLINT_MSIP_OFS), APB_DATA_W'(m_msip));
    end
  endtask

  task automatic timer_test();
    logic [MTIME_W-1:0] cnt;
    logic [MTIME_W-1:0] cmp;
    logic               old;
    int                 n;
    for (n = 0; n < N_TIMER; n++) begin
      cnt = rand_bits(MTIME_W);
      @(posedge clk);
      pad_cpu_sys_cnt <= cnt;
      m_cnt = cnt;
      // half the time land close to the counter
      if (rand_bits(1) != '0)
        cmp = cnt + 64'(rand_bits(3)) - 64'd4;
      else
        cmp = rand_bits(MTIME_W);
      bus_write(CLINT_BASE | APB_ADDR_W'(CLINT_MTIMECMP_LO_OFS), cmp[31:0]);
      bus_write(CLINT_BASE | APB_ADDR_W'(CLINT_MTIMECMP_HI_OFS), cmp[63:32]);
      m_cmp = cmp;
      settle(3);
      irq_check("core0_mt_int", m_cnt >= m_cmp, core0_mt_int);
      // exact latency from a counter step
      old = (m_cnt >= m_cmp);
      cnt = m_cmp + 64'(rand_bits(3)) - 64'd4;
      @(posedge clk);
      pad_cpu_sys_cnt <= cnt;
      m_cnt = cnt;
      settle(2);
      irq_check("core0_mt_int", old, core0_mt_int);
      settle(1);
      irq_check("core0_mt_int", m_cnt >= m_cmp, core0_mt_int);
      bus_read_check(CLINT_BASE | APB_ADDR_W'(CLINT_MTIME_LO_OFS), m_cnt[31:0]);
      bus_read_check(CLINT_BASE | APB_ADDR_W'(CLINT_MTIME_HI_OFS), m_cnt[63:32]);
      bus_read_check(CLINT_BASE | APB_ADDR_W'(CLINT_MTIMECMP_LO_OFS), m_cmp[31:0]);
      bus_read_check(CLINT_BASE | APB_ADDR_W'(CLINT_MTIMECMP_HI_OFS), m_cmp[63:32]);
    end
  endtask

  task automatic ext_irq_test();
    logic [APB_ADDR_W-1:0]    addr;
    logic [PLIC_ID_W-1:0]     src;
    logic [PLIC_PRIO_BIT-1:0] pr;
    logic [PLIC_ID_W-1:0]     win;
    int                       n;
    int                       j;
    for (n = 0; n < N_PLIC; n++) begin
      for (j = 0; j < 3; j++) begin
        src  = PLIC_ID_W'(rand_bits(PLIC_ID_W));
        pr   = PLIC_PRIO_BIT'(rand_bits(PLIC_PRIO_BIT));
        addr = PLIC_BASE | APB_ADDR_W'(PLIC_PRIO_OFS) | APB_ADDR_W'({src, 2'b00});
        bus_write(addr, APB_DATA_W'(pr));
        if (src != '0)
          m_prio[src] = pr; // source 0 stays hardwired
        bus_read_check(addr, APB_DATA_W'(m_prio[src]));
      end
      m_enable = PLIC_INT_NUM'(rand_bits(PLIC_INT_NUM));
      bus_write(PLIC_BASE | APB_ADDR_W'(PLIC_ENABLE_OFS), APB_DATA_W'(m_enable));
      m_thresh = PLIC_PRIO_BIT'(rand_bits(2)); // keep low so irqs fire
      bus_write(PLIC_BASE | APB_ADDR_W'(PLIC_THRESH_OFS), APB_DATA_W'(m_thresh));
      @(posedge clk);
      pad_plic_int_cfg <= PLIC_INT_NUM'(rand_bits(PLIC_INT_NUM));
      pad_plic_int_vld <= PLIC_INT_NUM'(rand_bits(PLIC_INT_NUM));
      settle(3);
      irq_check("core0_me_int", me_expected(), core0_me_int);
      bus_read_check(PLIC_BASE | APB_ADDR_W'(PLIC_PENDING_OFS), APB_DATA_W'(m_pend));
      @(negedge clk);
      win = winner_id();
      bus_read_check(PLIC_BASE | APB_ADDR_W'(PLIC_CLAIM_OFS), APB_DATA_W'(win));
      settle(3);
      irq_check("core0_me_int", me_expected(), core0_me_int);
      bus_read_check(PLIC_BASE | APB_ADDR_W'(PLIC_PENDING_OFS), APB_DATA_W'(m_pend));
    end
  endtask

  task automatic bus_error_test();
    logic [APB_ADDR_W-1:0] addr;
    logic [APB_DATA_W-1:0] rd;
    logic                  err;
    logic                  wr;
    logic [5:0]            top;
    int                    k;
    int                    n;
    for (n = 0; n < N_ERR; n++) begin
      k  = int'(rand_bits(3));
      wr = 1'(rand_bits(1));
      case (k)
        0, 1: begin
          top = 6'(rand_bits(6));
          if (top < 6'd2)
            top = top + 6'd2; // skip both mapped regions
          addr = {top, 26'(rand_bits(26))};
        end
        2: addr = CLINT_BASE | 32'h0000_8000 | {20'h0, 10'(rand_bits(10)), 2'b00};
        3: addr = PLIC_BASE | 32'h0000_3000 | {20'h0, 10'(rand_bits(10)), 2'b00};
        4: addr = PLIC_BASE | 32'h0000_0040 | {22'h0, 8'(rand_bits(8)), 2'b00};
        5: begin
          wr   = 1'b1;
          addr = CLINT_BASE | ((rand_bits(1) != '0) ? APB_ADDR_W'(CLINT_MTIME_LO_OFS)
                                                     : APB_ADDR_W'(CLINT_MTIME_HI_OFS));
        end
        6: begin
          wr   = 1'b1;
          addr = PLIC_BASE | APB_ADDR_W'(PLIC_PENDING_OFS);
        end
        default: addr = CLINT_BASE | 32'h0000_4010 | {22'h0, 8'(rand_bits(8)), 2'b00};
      endcase
      apb_xfer(wr, addr, APB_DATA_W'(rand_bits(APB_DATA_W)), rd, err);
      resp_check("pslverr", 1'b1, err);
      data_check("prdata", '0, rd);
    end
    // nothing moved
    bus_read_check(CLINT_BASE | APB_ADDR_W'(CLINT_MSIP_OFS), APB_DATA_W'(m_msip));
    bus_read_check(CLINT_BASE | APB_ADDR_W'(CLINT_MTIMECMP_LO_OFS), m_cmp[31:0]);
    bus_read_check(CLINT_BASE | APB_ADDR_W'(CLINT_MTIMECMP_HI_OFS), m_cmp[63:32]);
    bus_read_check(CLINT_BASE | APB_ADDR_W'(CLINT_MTIME_LO_OFS), m_cnt[31:0]);
    bus_read_check(PLIC_BASE | APB_ADDR_W'(PLIC_ENABLE_OFS), APB_DATA_W'(m_enable));
    bus_read_check(PLIC_BASE | APB_ADDR_W'(PLIC_THRESH_OFS), APB_DATA_W'(m_thresh));
    bus_read_check(PLIC_BASE | APB_ADDR_W'(PLIC_PENDING_OFS), APB_DATA_W'(m_pend));
  endtask

  task automatic wake_test();
    logic [APB_DATA_W-1:0] wd;
    logic [1:0]            lp;
    logic                  any;
    int                    n;
    for (n = 0; n < N_WAKE; n++) begin
      wd = APB_DATA_W'(rand_bits(APB_DATA_W));
      bus_write(CLINT_BASE | APB_ADDR_W'(CLINT_MSIP_OFS), wd);
      m_msip = wd[0];
      wd = (rand_bits(1) != '0) ? 32'h0 : 32'hffff_ffff;
      bus_write(CLINT_BASE | APB_ADDR_W'(CLINT_MTIMECMP_HI_OFS), wd);
      m_cmp[63:32] = wd;
      lp = 2'(rand_bits(2));
      if (rand_bits(1) != '0)
        lp = 2'b00;
      @(posedge clk);
      core0_lpmd_b <= lp;
      settle(3);
      any = m_msip || (m_cnt >= m_cmp) || me_expected();
      irq_check("core0_ms_int", m_msip, core0_ms_int);
      irq_check("core0_mt_int", m_cnt >= m_cmp, core0_mt_int);
      irq_check("core0_me_int", me_expected(), core0_me_int);
      irq_check("core0_wake", any && (lp == 2'b00), core0_wake);
    end
  endtask

  //============================================================
  //  main sequence
  //============================================================
  initial begin
    reset            = 1'b1;
    paddr            = '0;
    psel             = 1'b0;
    penable          = 1'b0;
    pwrite           = 1'b0;
    pwdata           = '0;
    pad_cpu_sys_cnt  = '0;
    pad_plic_int_vld = '0;
    pad_plic_int_cfg = '0;
    core0_lpmd_b     = 2'b11;
    lfsr             = 32'hbf2c;
    cycles           = 0;
    n_checks         = 0;
    n_data_err       = 0;
    n_resp_err       = 0;
    n_irq_err        = 0;
    m_msip           = 1'b0;
    m_cmp            = '1;
    m_cnt            = '0;
    m_enable         = '0;
    m_thresh         = '0;
    for (int i = 0; i < PLIC_INT_NUM; i++)
      m_prio[i] = '0;

    repeat (3) @(posedge clk);
    reset <= 1'b0;

    after_reset_checks();
    soft_irq_test();
    timer_test();
    ext_irq_test();
    bus_error_test();
    wake_test();

    $display("checks %0d, data errors %0d, resp errors %0d, irq errors %0d",
             n_checks, n_data_err, n_resp_err, n_irq_err);
    if (n_data_err + n_resp_err + n_irq_err == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/tb_clkgen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
  output logic clk
);

  localparam int HALF_NS = 50; // 100 ns period

  initial clk = 1'b0;

  always #(HALF_NS) clk = ~clk;

endmodule

`default_nettype wire
